// File: tb.f
src/cnn_geom_pkg.sv
src/cnn_num_pkg.sv
src/input_loader.sv
src/conv_window.sv
src/pool_quant.sv
src/fc_layer.sv
src/cnn_top.sv
tests/tb_cnn.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the CNN core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_cnn -f tb.f -o tb_cnn > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_cnn > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: tests/tb_cnn.sv
`timescale 1ns/10ps

module tb_cnn;

    import cnn_geom_pkg::*;
    import cnn_num_pkg::*;

    localparam int MAX_CYCLES = 6 * 120 + 4;  // six runs plus reset
    localparam int WAIT_LIMIT = 40;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid_i;
    logic mode_i;
    pix_t in_data_ch1_i, in_data_ch2_i;
    pix_t in_kernel_ch1_i, in_kernel_ch2_i;
    pix_t in_weight_i;
    logic out_valid_o;
    out_t out_data_o;

    pix_t ker_c1 [KER_DIM][KER_DIM];
    pix_t ker_c2 [KER_DIM][KER_DIM];
    pix_t wgt    [NUM_OUT][VEC_LEN];
    pix_t img_c1 [2][IMG_DIM][IMG_DIM];
    pix_t img_c2 [2][IMG_DIM][IMG_DIM];
    out_t exp_out [NUM_OUT];
    int   cycle_cnt = 0;

    cnn_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .in_valid_i(in_valid_i), .mode_i(mode_i),
        .in_data_ch1_i(in_data_ch1_i), .in_data_ch2_i(in_data_ch2_i),
        .in_kernel_ch1_i(in_kernel_ch1_i), .in_kernel_ch2_i(in_kernel_ch2_i),
        .in_weight_i(in_weight_i),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: simulation ran past %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "stopped by cycle limit");
        end
    end

    // ========================================================================
    // compare tasks
    // ========================================================================
    task automatic check_out(input out_t got, input out_t exp, input int index);
        if (got !== exp)
        begin
            $display("FAILED out_data_o[%0d]: got %h expected %h", index, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "output data mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED out_valid_o: got %h expected %h", got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "output valid mismatch");
        end
    endtask

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic void compute_expected(input logic mode);
        int fmap [FMAP_DIM][FMAP_DIM];
        int vec  [VEC_LEN];
        int sum;
        int blk;
        int acc;
        for (int im = 0; im < 2; im++)
        begin
            for (int r = 0; r < FMAP_DIM; r++)
            begin
                for (int c = 0; c < FMAP_DIM; c++)
                begin
                    sum = 0;
                    for (int kr = 0; kr < KER_DIM; kr++)
                    begin
                        for (int kc = 0; kc < KER_DIM; kc++)
                        begin
                            sum += int'(img_c1[im][r + kr][c + kc]) * int'(ker_c1[kr][kc]);
                            sum += int'(img_c2[im][r + kr][c + kc]) * int'(ker_c2[kr][kc]);
                        end
                    end
                    if (sum < 0)
                        sum = mode ? -sum : 0;  // abs or relu
                    fmap[r][c] = sum;
                end
            end
            for (int b = 0; b < NUM_BLOCKS; b++)
            begin
                blk = 0;  // activated values are never negative
                for (int dr = 0; dr < POOL_DIM; dr++)
                begin
                    for (int dc = 0; dc < POOL_DIM; dc++)
                    begin
                        if (fmap[2 * (b / 2) + dr][2 * (b % 2) + dc] > blk)
                            blk = fmap[2 * (b / 2) + dr][2 * (b % 2) + dc];
                    end
                end
                blk = blk >>> DEFAULT_QUANT_SHIFT;
                vec[im * NUM_BLOCKS + b] = (blk > int'(QMAX)) ? int'(QMAX) : blk;
            end
        end
        for (int o = 0; o < NUM_OUT; o++)
        begin
            acc = 0;
            for (int j = 0; j < VEC_LEN; j++)
                acc += vec[j] * int'(wgt[o][j]);
            exp_out[o] = out_t'(acc);
        end
    endfunction

    // ========================================================================
    // stimulus
    // ========================================================================
    function automatic pix_t rand_range(input int lo, input int hi);
        return pix_t'(lo + int'($urandom_range(hi - lo, 0)));
    endfunction

    task automatic fill_random(input int pix_lo, input int pix_hi,
                               input int ker_lo, input int ker_hi);
        for (int r = 0; r < KER_DIM; r++)
        begin
            for (int c = 0; c < KER_DIM; c++)
            begin
                ker_c1[r][c] = rand_range(ker_lo, ker_hi);
                ker_c2[r][c] = rand_range(ker_lo, ker_hi);
            end
        end
        for (int o = 0; o < NUM_OUT; o++)
            for (int j = 0; j < VEC_LEN; j++)
                wgt[o][j] = rand_range(-8, 7);
        for (int im = 0; im < 2; im++)
        begin
            for (int r = 0; r < IMG_DIM; r++)
            begin
                for (int c = 0; c < IMG_DIM; c++)
                begin
                    img_c1[im][r][c] = rand_range(pix_lo, pix_hi);
                    img_c2[im][r][c] = rand_range(pix_lo, pix_hi);
                end
            end
        end
    endtask

    task automatic clear_inputs();
        in_valid_i      = 1'b0;
        mode_i          = 1'b0;
        in_data_ch1_i   = '0;
        in_data_ch2_i   = '0;
        in_kernel_ch1_i = '0;
        in_kernel_ch2_i = '0;
        in_weight_i     = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drive_run(input logic mode);
        int pos;
        for (int k = 0; k < RUN_LEN; k++)
        begin
            pos = k % IMG_CYCLES;
            clear_inputs();
            in_valid_i = 1'b1;
            mode_i     = (k == 0) ? mode : ~mode;  // only k=0 counts
            if (k < KER_CYCLES)
            begin
                in_kernel_ch1_i = ker_c1[k / KER_DIM][k % KER_DIM];
                in_kernel_ch2_i = ker_c2[k / KER_DIM][k % KER_DIM];
            end
            if (k < WGT_CYCLES)
                in_weight_i = wgt[k / VEC_LEN][k % VEC_LEN];
            in_data_ch1_i = img_c1[k / IMG_CYCLES][pos / IMG_DIM][pos % IMG_DIM];
            in_data_ch2_i = img_c2[k / IMG_CYCLES][pos / IMG_DIM][pos % IMG_DIM];
            idle_cycles(1);
        end
        clear_inputs();
    endtask

    task automatic collect_outputs();
        int waited;
        waited = 0;
        while (!out_valid_o)
        begin
            if (waited == WAIT_LIMIT)
            begin
                $display("out_valid_o did not rise within %0d cycles", WAIT_LIMIT);
                $display("CHECKS FAILED");
                $fatal(1, "no output");
            end
            idle_cycles(1);
            waited++;
        end
        for (int i = 0; i < NUM_OUT; i++)
        begin
            check_valid(out_valid_o, 1'b1);
            check_out(out_data_o, exp_out[i], i);
            idle_cycles(1);
        end
        check_valid(out_valid_o, 1'b0);  // exactly four beats
        check_out(out_data_o, '0, NUM_OUT);
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic test_reset();
        for (int i = 0; i < 5; i++)
        begin
            check_valid(out_valid_o, 1'b0);
            check_out(out_data_o, '0, 0);
            idle_cycles(1);
        end
    endtask

    task automatic test_relu();
        fill_random(-8, 7, -8, 7);
        compute_expected(1'b0);
        drive_run(1'b0);
        collect_outputs();
        idle_cycles(20);
    endtask

    task automatic test_abs();
        out_t relu_out [NUM_OUT];
        logic differs;
        fill_random(0, 15, -8, 1);  // mostly negative sums
        compute_expected(1'b0);
        relu_out = exp_out;
        compute_expected(1'b1);
        differs = 1'b0;
        for (int i = 0; i < NUM_OUT; i++)
            if (relu_out[i] != exp_out[i])
                differs = 1'b1;
        if (!differs)
        begin
            $display("abs-mode data gives the same outputs as relu mode");
            $display("CHECKS FAILED");
            $fatal(1, "weak test data");
        end
        drive_run(1'b1);
        collect_outputs();
        idle_cycles(20);
    endtask

    task automatic test_saturation();
        int row_sum;
        fill_random(127, 127, 127, 127);
        for (int o = 0; o < NUM_OUT; o++)
        begin
            row_sum = 0;
            for (int j = 0; j < VEC_LEN; j++)
                row_sum += int'(wgt[o][j]);
            exp_out[o] = out_t'(127 * row_sum);  // every pooled value clips
        end
        drive_run(1'b0);
        collect_outputs();
        idle_cycles(20);
    endtask

    task automatic test_back_to_back();
        logic second_sent;
        second_sent = 1'b0;
        fill_random(-8, 7, -8, 7);
        compute_expected(1'b1);
        drive_run(1'b1);
        fill_random(-8, 7, -8, 7);  // second run's data, first run already sent
        fork
            begin
                collect_outputs();
                while (!second_sent)
                begin
                    check_valid(out_valid_o, 1'b0);  // quiet between runs
                    check_out(out_data_o, '0, NUM_OUT);
                    idle_cycles(1);
                end
            end
            begin
                idle_cycles(20);
                drive_run(1'b0);
                second_sent = 1'b1;
            end
        join
        compute_expected(1'b0);
        collect_outputs();
    endtask

    initial
    begin
        void'($urandom(32'h52238941));
        clear_inputs();
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_relu();
        test_abs();
        test_saturation();
        test_back_to_back();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: src/cnn_top.sv
`timescale 1ns/10ps

module cnn_top (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid_i,
    input  logic mode_i,
    input  cnn_num_pkg::pix_t in_data_ch1_i,
    input  cnn_num_pkg::pix_t in_data_ch2_i,
    input  cnn_num_pkg::pix_t in_kernel_ch1_i,
    input  cnn_num_pkg::pix_t in_kernel_ch2_i,
    input  cnn_num_pkg::pix_t in_weight_i,
    output logic out_valid_o,
    output cnn_num_pkg::out_t out_data_o
);

    import cnn_geom_pkg::*;
    import cnn_num_pkg::*;

    logic mode, conv_start, feat_valid, vec_valid;
    acc_t feat;
    pix_t ker_ch1 [KER_DIM][KER_DIM];
    pix_t ker_ch2 [KER_DIM][KER_DIM];
    pix_t img_ch1 [IMG_DIM][IMG_DIM];
    pix_t img_ch2 [IMG_DIM][IMG_DIM];
    pix_t weights [NUM_OUT][VEC_LEN];
    pix_t vec     [VEC_LEN];

    input_loader i_loader (
        .clk(clk), .rst_n(rst_n),
        .in_valid_i(in_valid_i), .mode_i(mode_i),
        .in_data_ch1_i(in_data_ch1_i), .in_data_ch2_i(in_data_ch2_i),
        .in_kernel_ch1_i(in_kernel_ch1_i), .in_kernel_ch2_i(in_kernel_ch2_i),
        .in_weight_i(in_weight_i),
        .mode_o(mode), .conv_start_o(conv_start),
        .ker_ch1_o(ker_ch1), .ker_ch2_o(ker_ch2),
        .img_ch1_o(img_ch1), .img_ch2_o(img_ch2),
        .weights_o(weights)
    );

    conv_window i_conv (
        .clk(clk), .rst_n(rst_n),
        .conv_start_i(conv_start), .mode_i(mode),
        .ker_ch1_i(ker_ch1), .ker_ch2_i(ker_ch2),
        .img_ch1_i(img_ch1), .img_ch2_i(img_ch2),
        .feat_valid_o(feat_valid), .feat_o(feat)
    );

    pool_quant #(.QUANT_SHIFT(DEFAULT_QUANT_SHIFT)) i_pool (
        .clk(clk), .rst_n(rst_n),
        .feat_valid_i(feat_valid), .feat_i(feat),
        .vec_valid_o(vec_valid), .vec_o(vec)
    );

    fc_layer i_fc (
        .clk(clk), .rst_n(rst_n),
        .vec_valid_i(vec_valid), .vec_i(vec), .weights_i(weights),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o)
    );

endmodule

// File: src/fc_layer.sv
`timescale 1ns/10ps

module fc_layer (
    input  logic clk,
    input  logic rst_n,
    input  logic vec_valid_i,
    input  cnn_num_pkg::pix_t vec_i [cnn_geom_pkg::VEC_LEN],
    input  cnn_num_pkg::pix_t weights_i [cnn_geom_pkg::NUM_OUT][cnn_geom_pkg::VEC_LEN],
    output logic out_valid_o,
    output cnn_num_pkg::out_t out_data_o
);

    import cnn_geom_pkg::*;
    import cnn_num_pkg::*;

    logic [1:0] row_q;   // output being computed
    logic       busy_q;  // rows 1..3
    logic       run;
    out_t       dot;

    assign run = vec_valid_i || busy_q;

    // one weight row per cycle
    always_comb
    begin
        dot = '0;
        for (int j = 0; j < VEC_LEN; j++)
            dot = dot + vec_i[j] * weights_i[row_q][j];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row_q       <= '0;
            busy_q      <= 1'b0;
            out_valid_o <= 1'b0;
            out_data_o  <= '0;
        end
        else
        begin
            out_valid_o <= run;
            out_data_o  <= run ? dot : '0;  // zero when idle
            if (run)
            begin
                row_q  <= row_q + 1'b1;
                busy_q <= (row_q != 2'(NUM_OUT - 1));
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid_o) |-> ##NUM_OUT !out_valid_o);

endmodule

// File: src/pool_quant.sv
`timescale 1ns/10ps

module pool_quant #(
    parameter int QUANT_SHIFT = cnn_num_pkg::DEFAULT_QUANT_SHIFT
) (
    input  logic clk,
    input  logic rst_n,
    input  logic feat_valid_i,
    input  cnn_num_pkg::acc_t feat_i,
    output logic vec_valid_o,
    output cnn_num_pkg::pix_t vec_o [cnn_geom_pkg::VEC_LEN]
);

    import cnn_geom_pkg::*;
    import cnn_num_pkg::*;

    localparam int   LAST_FEAT  = (VEC_LEN / NUM_BLOCKS) * FMAP_DIM * FMAP_DIM - 1;
    localparam int   LAST_ENTRY = VEC_LEN - 1;
    localparam acc_t SAT_LIM    = acc_t'(128 << QUANT_SHIFT);  // first value that clips

    logic [4:0] cnt_q;  // image, row, column of the incoming feature
    logic       f_img;
    logic [1:0] f_row, f_col;
    logic       blk_first, blk_last, run_end;
    logic [2:0] entry;
    acc_t       run_max;
    acc_t       blk_max;
    pix_t       q_val;

    acc_t max_q  [FMAP_DIM / POOL_DIM];  // one running max per block column
    pix_t work_q [VEC_LEN - 1];          // entries before the last one

    assign f_img     = cnt_q[4];
    assign f_row     = cnt_q[3:2];
    assign f_col     = cnt_q[1:0];
    assign blk_first = !f_row[0] && !f_col[0];
    assign blk_last  = f_row[0] && f_col[0];  // bottom-right of the block
    assign run_end   = feat_valid_i && (cnt_q == 5'(LAST_FEAT));
    assign entry     = {f_img, f_row[1], f_col[1]};
    assign run_max   = max_q[f_col[1]];

    assign blk_max = (blk_first || feat_i > run_max) ? feat_i : run_max;

    // input is never negative after activation
    assign q_val = (blk_max >= SAT_LIM) ? QMAX : pix_t'(blk_max >>> QUANT_SHIFT);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q       <= '0;
            vec_valid_o <= 1'b0;
        end
        else
        begin
            vec_valid_o <= run_end;
            if (feat_valid_i)
                cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (feat_valid_i)
        begin
            max_q[f_col[1]] <= blk_max;
            if (blk_last && entry != 3'(LAST_ENTRY))
                work_q[entry] <= q_val;
        end
        // publish the whole vector at once so it holds through the next run
        if (run_end)
        begin
            for (int i = 0; i < LAST_ENTRY; i++)
                vec_o[i] <= work_q[i];
            vec_o[LAST_ENTRY] <= q_val;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        feat_valid_i |-> !$isunknown(feat_i));

endmodule

// File: src/conv_window.sv
`timescale 1ns/10ps

module conv_window (
    input  logic clk,
    input  logic rst_n,
    input  logic conv_start_i,
    input  logic mode_i,
    input  cnn_num_pkg::pix_t ker_ch1_i [cnn_geom_pkg::KER_DIM][cnn_geom_pkg::KER_DIM],
    input  cnn_num_pkg::pix_t ker_ch2_i [cnn_geom_pkg::KER_DIM][cnn_geom_pkg::KER_DIM],
    input  cnn_num_pkg::pix_t img_ch1_i [cnn_geom_pkg::IMG_DIM][cnn_geom_pkg::IMG_DIM],
    input  cnn_num_pkg::pix_t img_ch2_i [cnn_geom_pkg::IMG_DIM][cnn_geom_pkg::IMG_DIM],
    output logic feat_valid_o,
    output cnn_num_pkg::acc_t feat_o
);

    import cnn_geom_pkg::*;
    import cnn_num_pkg::*;

    win_idx_t   idx_q;      // window in progress, 0 when idle
    logic       busy_q;     // windows 1..15
    logic       scan;
    logic [2:0] win_row, win_col;
    acc_t       conv_sum;
    acc_t       act;

    assign scan    = conv_start_i || busy_q;
    assign win_row = {1'b0, idx_q[3:2]};
    assign win_col = {1'b0, idx_q[1:0]};

    // ========================================================================
    // two-channel 3x3 sum, 18 products per cycle
    // ========================================================================
    always_comb
    begin
        conv_sum = '0;
        for (int r = 0; r < KER_DIM; r++)
        begin
            for (int c = 0; c < KER_DIM; c++)
            begin
                conv_sum = conv_sum
                         + img_ch1_i[win_row + r][win_col + c] * ker_ch1_i[r][c]
                         + img_ch2_i[win_row + r][win_col + c] * ker_ch2_i[r][c];
            end
        end
    end

    // mode 0 relu, mode 1 abs
    always_comb
    begin
        if (conv_sum < 0)
            act = mode_i ? -conv_sum : '0;
        else
            act = conv_sum;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx_q        <= '0;
            busy_q       <= 1'b0;
            feat_valid_o <= 1'b0;
        end
        else
        begin
            feat_valid_o <= scan;
            if (scan)
            begin
                idx_q  <= idx_q + 1'b1;  // wraps to 0 after the last window
                busy_q <= (idx_q != win_idx_t'(FMAP_DIM * FMAP_DIM - 1));
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (scan)
            feat_o <= act;
    end

    // loader must not restart a scan before the previous image is done
    assert property (@(posedge clk) disable iff (!rst_n)
        conv_start_i |-> !busy_q);

endmodule

// File: src/input_loader.sv
`timescale 1ns/10ps

module input_loader (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid_i,
    input  logic mode_i,
    input  cnn_num_pkg::pix_t in_data_ch1_i,
    input  cnn_num_pkg::pix_t in_data_ch2_i,
    input  cnn_num_pkg::pix_t in_kernel_ch1_i,
    input  cnn_num_pkg::pix_t in_kernel_ch2_i,
    input  cnn_num_pkg::pix_t in_weight_i,
    output logic mode_o,
    output logic conv_start_o,
    output cnn_num_pkg::pix_t ker_ch1_o [cnn_geom_pkg::KER_DIM][cnn_geom_pkg::KER_DIM],
    output cnn_num_pkg::pix_t ker_ch2_o [cnn_geom_pkg::KER_DIM][cnn_geom_pkg::KER_DIM],
    output cnn_num_pkg::pix_t img_ch1_o [cnn_geom_pkg::IMG_DIM][cnn_geom_pkg::IMG_DIM],
    output cnn_num_pkg::pix_t img_ch2_o [cnn_geom_pkg::IMG_DIM][cnn_geom_pkg::IMG_DIM],
    output cnn_num_pkg::pix_t weights_o [cnn_geom_pkg::NUM_OUT][cnn_geom_pkg::VEC_LEN]
);

    import cnn_geom_pkg::*;
    import cnn_num_pkg::*;

    run_cnt_t   cnt_q;       // k of the current in_valid cycle
    run_cnt_t   img_pos;     // pixel index within its image
    logic       img_sel;     // 0: image 1, 1: image 2
    logic       img_done;    // last pixel of an image
    logic       cur_img_q;   // image handed to the conv engine
    logic [2:0] img_row, img_col;
    logic [1:0] ker_row, ker_col;
    logic [1:0] wgt_row;
    logic [2:0] wgt_col;

    // two image buffers, image 2 fills while image 1 is convolved
    pix_t img_ch1_q [2][IMG_DIM][IMG_DIM];
    pix_t img_ch2_q [2][IMG_DIM][IMG_DIM];

    assign img_sel  = (cnt_q >= run_cnt_t'(IMG_CYCLES));
    assign img_pos  = img_sel ? cnt_q - run_cnt_t'(IMG_CYCLES) : cnt_q;
    assign img_done = in_valid_i && (img_pos == run_cnt_t'(IMG_CYCLES - 1));

    assign img_row = 3'(img_pos / IMG_DIM);
    assign img_col = 3'(img_pos % IMG_DIM);
    assign ker_row = 2'(cnt_q / KER_DIM);
    assign ker_col = 2'(cnt_q % KER_DIM);
    assign wgt_row = 2'(cnt_q / VEC_LEN);
    assign wgt_col = 3'(cnt_q % VEC_LEN);

    // ========================================================================
    // run counter and conv start
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q        <= '0;
            conv_start_o <= 1'b0;
            cur_img_q    <= 1'b0;
        end
        else
        begin
            cnt_q        <= in_valid_i ? cnt_q + 1'b1 : '0;
            conv_start_o <= img_done;  // cycle after k=35 / k=71
            if (img_done)
                cur_img_q <= img_sel;
        end
    end

    // ========================================================================
    // input stores
    // ========================================================================
    always_ff @(posedge clk)
    begin
        if (in_valid_i && cnt_q == '0)
            mode_o <= mode_i;
        if (in_valid_i && cnt_q < run_cnt_t'(KER_CYCLES))
        begin
            ker_ch1_o[ker_row][ker_col] <= in_kernel_ch1_i;
            ker_ch2_o[ker_row][ker_col] <= in_kernel_ch2_i;
        end
        if (in_valid_i && cnt_q < run_cnt_t'(WGT_CYCLES))
            weights_o[wgt_row][wgt_col] <= in_weight_i;  // one row per output
        if (in_valid_i && cnt_q < run_cnt_t'(RUN_LEN))
        begin
            img_ch1_q[img_sel][img_row][img_col] <= in_data_ch1_i;
            img_ch2_q[img_sel][img_row][img_col] <= in_data_ch2_i;
        end
    end

    assign img_ch1_o = img_ch1_q[cur_img_q];
    assign img_ch2_o = img_ch2_q[cur_img_q];

    // a run is exactly RUN_LEN cycles of in_valid
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid_i |-> cnt_q < run_cnt_t'(RUN_LEN));

endmodule

// File: src/cnn_num_pkg.sv
package cnn_num_pkg;

    // ========================================================================
    // number formats
    // ========================================================================

    // pixels, kernel taps, weights and quantized values
    typedef logic signed [7:0] pix_t;

    // 18 products of 8x8 bits
    typedef logic signed [20:0] acc_t;

    // fc dot product, 8 terms
    typedef logic signed [19:0] out_t;

    // ========================================================================
    // quantization
    // ========================================================================

    // feature >>> 9 gives the 8-bit value
    parameter int DEFAULT_QUANT_SHIFT = 9;

    parameter pix_t QMAX = 8'sd127;  // positive clip

endpackage

// File: src/cnn_geom_pkg.sv
package cnn_geom_pkg;

    // ========================================================================
    // network geometry
    // ========================================================================
    parameter int IMG_DIM    = 6;  // image side
    parameter int KER_DIM    = 3;  // kernel side
    parameter int FMAP_DIM   = 4;  // IMG_DIM - KER_DIM + 1
    parameter int POOL_DIM   = 2;  // pooling block side
    parameter int NUM_BLOCKS = 4;  // pooled values per image
    parameter int VEC_LEN    = 8;  // two images worth of pooled values
    parameter int NUM_OUT    = 4;  // fc rows

    // ========================================================================
    // input schedule, in in_valid cycles
    // ========================================================================
    parameter int RUN_LEN    = 72;
    parameter int KER_CYCLES = 9;   // k 0..8
    parameter int WGT_CYCLES = 32;  // k 0..31
    parameter int IMG_CYCLES = 36;  // per image

    // 16 window positions of one image
    typedef logic [3:0] win_idx_t;

    // counts up to RUN_LEN
    typedef logic [6:0] run_cnt_t;

endpackage
